// File: design/dma_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Geometry, request types and TCDM address decode for the DMA front end
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package dma_pkg;

  localparam int unsigned NumGroups        = 4;
  localparam int unsigned NumBanksPerGroup = 4;
  localparam int unsigned BankBytes        = 4;
  localparam int unsigned StripeBytes      = NumBanksPerGroup * BankBytes;
  localparam int unsigned RowBytes         = NumGroups * StripeBytes;
  localparam int unsigned AddrWidth        = 32;
  localparam logic [AddrWidth-1:0] TcdmBaseAddr = 32'h0001_0000;
  localparam int unsigned TcdmSize         = 4096;
  localparam int unsigned LenWidth         = 16;
  localparam int unsigned TrackDepth       = 4;
  localparam int unsigned TrackPtrWidth    = $clog2(TrackDepth);
  localparam int unsigned CntWidth         = 4;
  localparam int unsigned GroupIdxWidth    = $clog2(NumGroups);
  localparam int unsigned StripeOffWidth   = $clog2(StripeBytes);
  localparam int unsigned RowOffWidth      = $clog2(RowBytes);
  localparam int unsigned RowIdxWidth      = $clog2(TcdmSize) - RowOffWidth;
  localparam int unsigned TagWidth         = AddrWidth - $clog2(TcdmSize);

  typedef struct packed {
    logic [AddrWidth-1:0] src;
    logic [AddrWidth-1:0] dst;
    logic [LenWidth-1:0]  num_bytes;
  } dma_req_t;

  typedef logic [NumGroups-1:0] group_mask_t;

  // Bank geometry view of a TCDM byte address
  typedef struct packed {
    logic [TagWidth-1:0]                 tag;
    logic [RowIdxWidth-1:0]              row;
    logic [GroupIdxWidth-1:0]            group;
    logic [$clog2(NumBanksPerGroup)-1:0] bank;
    logic [$clog2(BankBytes)-1:0]        offset;
  } tcdm_geo_t;

  typedef union packed {
    logic [AddrWidth-1:0] raw;
    tcdm_geo_t            geo;
  } tcdm_addr_u;

  function automatic logic in_tcdm(input logic [AddrWidth-1:0] addr);
    return (addr >= TcdmBaseAddr) && (addr < TcdmBaseAddr + TcdmSize);
  endfunction

endpackage

`default_nettype wire

// File: design/dma_spill_register.sv
////////////////////////////////////////////////////////////////////////////
// Two-entry valid/ready spill register for one DMA request word
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_spill_register (
  input  logic              clk_i,
  input  logic              rst_i,
  input  dma_pkg::dma_req_t data_i,
  input  logic              valid_i,
  output logic              ready_o,
  output dma_pkg::dma_req_t data_o,
  output logic              valid_o,
  input  logic              ready_i
);
  import dma_pkg::*;

  dma_req_t out_data_q;
  dma_req_t spill_data_q;
  logic     out_full_q;
  logic     spill_full_q;
  logic     in_xfer;
  logic     out_xfer;

  assign in_xfer  = valid_i && ready_o;
  assign out_xfer = out_full_q && ready_i;

  // Ready only looks at the spill slot, never at ready_i
  assign ready_o = !spill_full_q;
  assign valid_o = out_full_q;
  assign data_o  = out_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_full_q   <= 1'b0;
      spill_full_q <= 1'b0;
    end else if (spill_full_q) begin
      if (out_xfer) begin
        spill_full_q <= 1'b0;
      end
    end else if (in_xfer) begin
      if (out_full_q && !out_xfer) begin
        spill_full_q <= 1'b1;
      end else begin
        out_full_q <= 1'b1;
      end
    end else if (out_xfer) begin
      out_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (spill_full_q) begin
      if (out_xfer) begin
        out_data_q <= spill_data_q;
      end
    end else if (in_xfer) begin
      if (out_full_q && !out_xfer) begin
        spill_data_q <= data_i;
      end else begin
        out_data_q <= data_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/dma_row_splitter.sv
////////////////////////////////////////////////////////////////////////////
// Cuts a DMA request into pieces that stay inside one TCDM row
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_row_splitter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  dma_pkg::dma_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output dma_pkg::dma_req_t piece_o,
  output logic              piece_valid_o,
  output logic              piece_last_o,
  input  logic              piece_ready_i
);
  import dma_pkg::*;

  dma_req_t            cur_q;
  logic                busy_q;
  tcdm_addr_u          cut_addr;
  logic                use_dst;
  logic                is_tcdm;
  logic                fits;
  logic                piece_xfer;
  logic                req_xfer;
  logic [LenWidth-1:0] to_row_end;
  logic [LenWidth-1:0] piece_len;

  // Destination wins when both addresses are in the TCDM
  always_comb begin
    use_dst      = in_tcdm(cur_q.dst);
    is_tcdm      = use_dst || in_tcdm(cur_q.src);
    cut_addr.raw = use_dst ? cur_q.dst : cur_q.src;
  end

  // Bytes left up to the next row boundary
  assign to_row_end = LenWidth'(RowBytes) - LenWidth'({cut_addr.geo.group,
                                                       cut_addr.geo.bank,
                                                       cut_addr.geo.offset});

  assign fits      = !is_tcdm || (cur_q.num_bytes <= to_row_end);
  assign piece_len = fits ? cur_q.num_bytes : to_row_end;

  assign piece_o.src       = cur_q.src;
  assign piece_o.dst       = cur_q.dst;
  assign piece_o.num_bytes = piece_len;
  assign piece_valid_o     = busy_q;
  assign piece_last_o      = fits;

  assign piece_xfer  = busy_q && piece_ready_i;
  assign req_ready_o = !busy_q || (piece_xfer && fits);
  assign req_xfer    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else if (req_xfer) begin
      busy_q <= 1'b1;
    end else if (piece_xfer && fits) begin
      busy_q <= 1'b0;
    end
  end

  // Both sides advance by the same amount
  always_ff @(posedge clk_i) begin
    if (req_xfer) begin
      cur_q <= req_i;
    end else if (piece_xfer) begin
      cur_q.src       <= cur_q.src + AddrWidth'(piece_len);
      cur_q.dst       <= cur_q.dst + AddrWidth'(piece_len);
      cur_q.num_bytes <= cur_q.num_bytes - piece_len;
    end
  end

endmodule

`default_nettype wire

// File: design/dma_group_distributor.sv
////////////////////////////////////////////////////////////////////////////
// Fans one row piece out to the groups owning its bank stripes
// and reports the completed fan-out to the tracker
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_group_distributor (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  input  dma_pkg::dma_req_t                         piece_i,
  input  logic                                      piece_valid_i,
  input  logic                                      piece_last_i,
  output logic                                      piece_ready_o,
  output dma_pkg::dma_req_t [dma_pkg::NumGroups-1:0] group_req_o,
  output dma_pkg::group_mask_t                      group_req_valid_o,
  input  dma_pkg::group_mask_t                      group_req_ready_i,
  output logic                                      issue_valid_o,
  output dma_pkg::group_mask_t                      issue_mask_o,
  output logic                                      issue_last_o,
  input  logic                                      issue_ready_i
);
  import dma_pkg::*;

  tcdm_addr_u               tcdm_addr;
  logic                     use_dst;
  logic                     is_tcdm;
  logic [RowOffWidth:0]     row_off;
  logic [RowOffWidth:0]     row_end;
  logic [RowOffWidth:0]     end_byte;
  logic [GroupIdxWidth-1:0] last_grp;
  group_mask_t              part_mask;
  group_mask_t              sent_q;
  group_mask_t              accepted;
  logic                     all_accepted;

  always_comb begin
    use_dst       = in_tcdm(piece_i.dst);
    is_tcdm       = use_dst || in_tcdm(piece_i.src);
    tcdm_addr.raw = use_dst ? piece_i.dst : piece_i.src;
  end

  // Piece never crosses a row, so its end fits the row offset range
  assign row_off  = {1'b0, tcdm_addr.geo.group, tcdm_addr.geo.bank, tcdm_addr.geo.offset};
  assign row_end  = row_off + piece_i.num_bytes[RowOffWidth:0];
  assign end_byte = row_end - 1'b1;
  assign last_grp = end_byte[RowOffWidth-1:StripeOffWidth];

  always_comb begin
    logic [RowOffWidth:0]  lo;
    logic [RowOffWidth:0]  hi;
    logic [AddrWidth-1:0]  skip;
    part_mask = '0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      lo   = (g == tcdm_addr.geo.group) ? row_off : (RowOffWidth+1)'(g * StripeBytes);
      hi   = (g == last_grp) ? row_end : (RowOffWidth+1)'((g + 1) * StripeBytes);
      skip = AddrWidth'(lo - row_off);
      group_req_o[g].src       = piece_i.src + skip;
      group_req_o[g].dst       = piece_i.dst + skip;
      group_req_o[g].num_bytes = LenWidth'(hi - lo);
      part_mask[g] = is_tcdm && (piece_i.num_bytes != '0) &&
                     (g >= tcdm_addr.geo.group) && (g <= last_grp);
    end
    // Outside the TCDM or empty, the whole piece goes to group 0
    if (!is_tcdm || (piece_i.num_bytes == '0)) begin
      part_mask      = group_mask_t'(1);
      group_req_o[0] = piece_i;
    end
  end

  assign group_req_valid_o = {NumGroups{piece_valid_i}} & part_mask & ~sent_q;
  assign accepted          = group_req_valid_o & group_req_ready_i;
  assign all_accepted      = &(~part_mask | sent_q | accepted);

  assign issue_valid_o = piece_valid_i && all_accepted;
  assign issue_mask_o  = part_mask;
  assign issue_last_o  = piece_last_i;
  assign piece_ready_o = issue_valid_o && issue_ready_i;

  // Groups that already took their part of the current piece
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sent_q <= '0;
    end else if (piece_valid_i && piece_ready_o) begin
      sent_q <= '0;
    end else if (piece_valid_i) begin
      sent_q <= sent_q | accepted;
    end
  end

endmodule

`default_nettype wire

// File: design/dma_completion_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Per-request piece accounting and cluster DMA status
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_completion_tracker (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 issue_valid_i,
  input  dma_pkg::group_mask_t issue_mask_i,
  input  logic                 issue_last_i,
  output logic                 issue_ready_o,
  input  dma_pkg::group_mask_t group_done_i,
  input  dma_pkg::group_mask_t group_idle_i,
  output logic                 trans_complete_o,
  output logic                 backend_idle_o
);
  import dma_pkg::*;

  group_mask_t                         done_q;
  logic [NumGroups-1:0][CntWidth-1:0]  cur_cnt_q;
  logic [NumGroups-1:0][CntWidth-1:0]  cur_cnt_d;
  logic [NumGroups-1:0][CntWidth-1:0]  done_cnt_q;
  logic [NumGroups-1:0][CntWidth-1:0]  done_cnt_d;
  logic [NumGroups-1:0][CntWidth-1:0]  head_cnt;
  logic [NumGroups-1:0][CntWidth-1:0]  fifo_q [TrackDepth];
  logic [TrackPtrWidth-1:0]            wr_ptr_q;
  logic [TrackPtrWidth-1:0]            rd_ptr_q;
  logic [TrackPtrWidth:0]              fill_q;
  logic [TrackPtrWidth:0]              fill_d;
  logic                                issue_xfer;
  logic                                push;
  logic                                pop;
  logic                                idle_d;

  assign issue_ready_o = (fill_q != (TrackPtrWidth+1)'(TrackDepth));
  assign issue_xfer    = issue_valid_i && issue_ready_o;
  assign push          = issue_xfer && issue_last_i;
  assign head_cnt      = fifo_q[rd_ptr_q];

  always_comb begin
    // Skip a cycle after each pulse so pulses never touch
    pop = (fill_q != '0) && !trans_complete_o;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      if (done_cnt_q[g] < head_cnt[g]) begin
        pop = 1'b0;
      end
    end
    for (int unsigned g = 0; g < NumGroups; g++) begin
      cur_cnt_d[g]  = cur_cnt_q[g] + CntWidth'(issue_xfer && issue_mask_i[g]);
      done_cnt_d[g] = done_cnt_q[g] + CntWidth'(done_q[g]) - (pop ? head_cnt[g] : '0);
    end
    fill_d = fill_q + (TrackPtrWidth+1)'(push) - (TrackPtrWidth+1)'(pop);
    idle_d = (&group_idle_i) && (fill_d == '0) && (push || (cur_cnt_d == '0));
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q           <= '0;
      cur_cnt_q        <= '0;
      done_cnt_q       <= '0;
      wr_ptr_q         <= '0;
      rd_ptr_q         <= '0;
      fill_q           <= '0;
      trans_complete_o <= 1'b0;
      backend_idle_o   <= 1'b1;
    end else begin
      done_q           <= group_done_i;
      cur_cnt_q        <= push ? '0 : cur_cnt_d;
      done_cnt_q       <= done_cnt_d;
      wr_ptr_q         <= wr_ptr_q + TrackPtrWidth'(push);
      rd_ptr_q         <= rd_ptr_q + TrackPtrWidth'(pop);
      fill_q           <= fill_d;
      trans_complete_o <= pop;
      backend_idle_o   <= idle_d;
    end
  end

  // Part counts of each fully issued request
  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= cur_cnt_d;
    end
  end

endmodule

`default_nettype wire

// File: design/dma_cluster_frontend.sv
////////////////////////////////////////////////////////////////////////////
// Cluster DMA front end with input register, row splitter, group fan-out,
// per-group registers and completion tracking
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_cluster_frontend (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  // Incoming copy request
  input  dma_pkg::dma_req_t                          dma_req_i,
  input  logic                                       dma_req_valid_i,
  output logic                                       dma_req_ready_o,
  // Group request links
  output dma_pkg::dma_req_t [dma_pkg::NumGroups-1:0] group_req_o,
  output dma_pkg::group_mask_t                       group_req_valid_o,
  input  dma_pkg::group_mask_t                       group_req_ready_i,
  // Group status
  input  dma_pkg::group_mask_t                       group_done_i,
  input  dma_pkg::group_mask_t                       group_idle_i,
  // Cluster status
  output logic                                       trans_complete_o,
  output logic                                       backend_idle_o
);
  import dma_pkg::*;

  dma_req_t                 req_cut;
  logic                     req_cut_valid;
  logic                     req_cut_ready;
  dma_req_t                 piece;
  logic                     piece_valid;
  logic                     piece_last;
  logic                     piece_ready;
  dma_req_t [NumGroups-1:0] group_req;
  group_mask_t              group_req_valid;
  group_mask_t              group_req_ready;
  logic                     issue_valid;
  group_mask_t              issue_mask;
  logic                     issue_last;
  logic                     issue_ready;

  dma_spill_register i_dma_req_register (
    .clk_i  (clk_i          ),
    .rst_i  (rst_i          ),
    .data_i (dma_req_i      ),
    .valid_i(dma_req_valid_i),
    .ready_o(dma_req_ready_o),
    .data_o (req_cut        ),
    .valid_o(req_cut_valid  ),
    .ready_i(req_cut_ready  )
  );

  dma_row_splitter i_row_splitter (
    .clk_i        (clk_i        ),
    .rst_i        (rst_i        ),
    .req_i        (req_cut      ),
    .req_valid_i  (req_cut_valid),
    .req_ready_o  (req_cut_ready),
    .piece_o      (piece        ),
    .piece_valid_o(piece_valid  ),
    .piece_last_o (piece_last   ),
    .piece_ready_i(piece_ready  )
  );

  dma_group_distributor i_group_distributor (
    .clk_i            (clk_i          ),
    .rst_i            (rst_i          ),
    .piece_i          (piece          ),
    .piece_valid_i    (piece_valid    ),
    .piece_last_i     (piece_last     ),
    .piece_ready_o    (piece_ready    ),
    .group_req_o      (group_req      ),
    .group_req_valid_o(group_req_valid),
    .group_req_ready_i(group_req_ready),
    .issue_valid_o    (issue_valid    ),
    .issue_mask_o     (issue_mask     ),
    .issue_last_o     (issue_last     ),
    .issue_ready_i    (issue_ready    )
  );

  // One register cut per group link
  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_register
    dma_spill_register i_group_register (
      .clk_i  (clk_i               ),
      .rst_i  (rst_i               ),
      .data_i (group_req[g]        ),
      .valid_i(group_req_valid[g]  ),
      .ready_o(group_req_ready[g]  ),
      .data_o (group_req_o[g]      ),
      .valid_o(group_req_valid_o[g]),
      .ready_i(group_req_ready_i[g])
    );
  end : gen_group_register

  dma_completion_tracker i_completion_tracker (
    .clk_i           (clk_i           ),
    .rst_i           (rst_i           ),
    .issue_valid_i   (issue_valid     ),
    .issue_mask_i    (issue_mask      ),
    .issue_last_i    (issue_last      ),
    .issue_ready_o   (issue_ready     ),
    .group_done_i    (group_done_i    ),
    .group_idle_i    (group_idle_i    ),
    .trans_complete_o(trans_complete_o),
    .backend_idle_o  (backend_idle_o  )
  );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock (10 ns period) and synchronous reset generator
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  always begin
    clk_o = 1'b0;
    #5;
    clk_o = 1'b1;
    #5;
  end

  // Reset held for two rising edges
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/dma_cluster_assert.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on group link stability, completion pulses and reset
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dma_cluster_assert (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic                                       req_ready_i,
  input  dma_pkg::dma_req_t [dma_pkg::NumGroups-1:0] grp_req_i,
  input  dma_pkg::group_mask_t                       grp_valid_i,
  input  dma_pkg::group_mask_t                       grp_ready_i,
  input  logic                                       complete_i,
  input  logic                                       idle_i
);
  import dma_pkg::*;

  // A stalled group request keeps its valid and its data
  for (genvar g = 0; g < NumGroups; g++) begin : gen_stable
    a_group_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      grp_valid_i[g] && !grp_ready_i[g] |=> grp_valid_i[g] && $stable(grp_req_i[g]))
      else $error("group %0d request changed while stalled", g);
  end : gen_stable

  a_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    complete_i |=> !complete_i)
    else $error("trans_complete_o high for two cycles");

  a_reset_values: assert property (@(posedge clk_i)
    $fell(rst_i) |-> req_ready_i && (grp_valid_i == '0) && !complete_i && idle_i)
    else $error("outputs differ from reset values after reset");

endmodule

`default_nettype wire

// File: tb/tb_dma_cluster.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the cluster DMA front end with group models, reference
// model of row cuts and stripe fan-out, completion checks and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_dma_cluster;
  import dma_pkg::*;

  localparam int MaxPatterns      = 32;
  localparam int CyclesPerPattern = 200;

  logic                     clk;
  logic                     rst;
  dma_req_t                 dma_req;
  logic                     dma_req_valid;
  logic                     dma_req_ready;
  dma_req_t [NumGroups-1:0] group_req;
  group_mask_t              group_req_valid;
  group_mask_t              group_req_ready = '0;
  group_mask_t              group_done = '0;
  group_mask_t              group_idle = '1;
  logic                     trans_complete;
  logic                     backend_idle;

  logic [31:0] pattern_mem [3*MaxPatterns];
  int          num_patterns;
  logic        patterns_loaded = 1'b0;
  logic [31:0] rng_state = 32'h1861_efc4;
  dma_req_t    expected_q [NumGroups][$];
  int          parts_per_req [MaxPatterns][NumGroups];
  int          done_given [NumGroups];
  int          done_needed [NumGroups];
  int          pending [NumGroups];
  int          delay [NumGroups];
  int          completions;
  int          errors;
  int          tests;
  int          tests_failed;
  int          errors_at_last_test;

  tb_clock_gen i_clock_gen (
    .clk_o(clk),
    .rst_o(rst)
  );

  dma_cluster_frontend DUT (
    .clk_i            (clk            ),
    .rst_i            (rst            ),
    .dma_req_i        (dma_req        ),
    .dma_req_valid_i  (dma_req_valid  ),
    .dma_req_ready_o  (dma_req_ready  ),
    .group_req_o      (group_req      ),
    .group_req_valid_o(group_req_valid),
    .group_req_ready_i(group_req_ready),
    .group_done_i     (group_done     ),
    .group_idle_i     (group_idle     ),
    .trans_complete_o (trans_complete ),
    .backend_idle_o   (backend_idle   )
  );

  bind dma_cluster_frontend dma_cluster_assert i_assert (
    .clk_i      (clk_i            ),
    .rst_i      (rst_i            ),
    .req_ready_i(dma_req_ready_o  ),
    .grp_req_i  (group_req_o      ),
    .grp_valid_i(group_req_valid_o),
    .grp_ready_i(group_req_ready_i),
    .complete_i (trans_complete_o ),
    .idle_i     (backend_idle_o   )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Offset from the TCDM base wraps to a large value below the base
  function automatic bit addr_in_tcdm(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - TcdmBaseAddr;
    return offset < TcdmSize;
  endfunction

  task automatic add_part(input int idx, input int g, input dma_req_t part);
    expected_q[g].push_back(part);
    parts_per_req[idx][g]++;
  endtask

  // Row cuts on the TCDM-side address, then one part per touched stripe
  task automatic expect_request(input int idx, input dma_req_t req);
    dma_req_t    rest;
    dma_req_t    part;
    logic [31:0] cut;
    int          row_off;
    int          len;
    int          lo;
    int          hi;
    bit          last;
    rest = req;
    last = 1'b0;
    while (!last) begin
      if (!addr_in_tcdm(rest.dst) && !addr_in_tcdm(rest.src)) begin
        add_part(idx, 0, rest);
        last = 1'b1;
      end else begin
        cut     = addr_in_tcdm(rest.dst) ? rest.dst : rest.src;
        row_off = int'(cut % RowBytes);
        len     = RowBytes - row_off;
        if (int'(rest.num_bytes) <= len) begin
          len  = int'(rest.num_bytes);
          last = 1'b1;
        end
        if (len == 0) begin
          add_part(idx, 0, rest);
        end
        for (int g = 0; g < NumGroups; g++) begin
          lo = (row_off > g * StripeBytes) ? row_off : g * StripeBytes;
          hi = (row_off + len < (g + 1) * StripeBytes) ? row_off + len : (g + 1) * StripeBytes;
          if (hi > lo) begin
            part.src       = rest.src + 32'(lo - row_off);
            part.dst       = rest.dst + 32'(lo - row_off);
            part.num_bytes = 16'(hi - lo);
            add_part(idx, g, part);
          end
        end
        rest.src       = rest.src + 32'(len);
        rest.dst       = rest.dst + 32'(len);
        rest.num_bytes = rest.num_bytes - 16'(len);
      end
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    if (errors == errors_at_last_test) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
    errors_at_last_test = errors;
  endtask

  // Group models driven on the falling edge
  always @(negedge clk) begin : group_models
    dma_req_t got;
    dma_req_t exp;
    if (!rst) begin
      if (trans_complete) begin
        if (completions >= num_patterns) begin
          $display("completion pulse seen with no request outstanding at %0t", $time);
          errors++;
        end else begin
          for (int g = 0; g < NumGroups; g++) begin
            done_needed[g] += parts_per_req[completions][g];
            if (done_given[g] < done_needed[g]) begin
              $display("mismatch at %0t: request %0d completed before group %0d was done",
                       $time, completions, g);
              errors++;
            end
          end
          report_test($sformatf("request %0d", completions));
          completions++;
        end
      end
      for (int g = 0; g < NumGroups; g++) begin
        group_done[g] = 1'b0;
        if (pending[g] > 0) begin
          if (delay[g] == 0) begin
            group_done[g] = 1'b1;
            pending[g]--;
            done_given[g]++;
            delay[g] = int'(next_random() % 6);
          end else begin
            delay[g]--;
          end
        end
        group_req_ready[g] = (next_random() % 4) != 0;
        // Transfer happens on the coming rising edge
        if (group_req_valid[g] && group_req_ready[g]) begin
          got = group_req[g];
          if (expected_q[g].size() == 0) begin
            $display("group %0d received a part that no request should produce", g);
            errors++;
          end else begin
            exp = expected_q[g].pop_front();
            if (got != exp) begin
              $display("mismatch at %0t: group %0d got %h/%h/%h, expected %h/%h/%h", $time,
                       g, got.src, got.dst, got.num_bytes, exp.src, exp.dst, exp.num_bytes);
              errors++;
            end
          end
          if (pending[g] == 0) begin
            delay[g] = int'(next_random() % 6);
          end
          pending[g]++;
        end
        group_idle[g] = (pending[g] == 0);
      end
    end
  end

  initial begin
    dma_req_t req;
    int       low_cycles;
    dma_req       = '0;
    dma_req_valid = 1'b0;
    for (int i = 0; i < 3 * MaxPatterns; i++) begin
      pattern_mem[i] = 32'hFFFF_0000 | 32'(i);
    end
    $readmemh("tb/dma_patterns.txt", pattern_mem);
    num_patterns = 0;
    while (num_patterns < MaxPatterns &&
           pattern_mem[3 * num_patterns + 2][31:16] == 16'h0000) begin
      num_patterns++;
    end
    patterns_loaded = 1'b1;
    if (num_patterns == 0) begin
      $display("no request patterns could be read");
      errors++;
    end

    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    if (!dma_req_ready || group_req_valid != '0 || trans_complete || !backend_idle) begin
      $display("mismatch at %0t: outputs after reset are %b %b %b %b", $time,
               dma_req_ready, group_req_valid, trans_complete, backend_idle);
      errors++;
    end
    report_test("reset values");

    for (int k = 0; k < num_patterns; k++) begin
      req.src       = pattern_mem[3 * k];
      req.dst       = pattern_mem[3 * k + 1];
      req.num_bytes = pattern_mem[3 * k + 2][15:0];
      expect_request(k, req);
      dma_req       = req;
      dma_req_valid = 1'b1;
      while (!dma_req_ready) begin
        @(negedge clk);
      end
      @(negedge clk);
      if ((next_random() % 3) == 0) begin
        dma_req_valid = 1'b0;
        repeat (int'(next_random() % 5)) @(negedge clk);
      end
    end
    dma_req_valid = 1'b0;

    while (completions < num_patterns) begin
      @(negedge clk);
    end
    while (!backend_idle) begin
      @(negedge clk);
    end
    low_cycles = 0;
    repeat (20) begin
      @(negedge clk);
      if (!backend_idle) begin
        low_cycles++;
      end
    end
    if (low_cycles != 0) begin
      $display("mismatch at %0t: backend_idle_o low for %0d cycles after the last completion",
               $time, low_cycles);
      errors++;
    end
    for (int g = 0; g < NumGroups; g++) begin
      if (expected_q[g].size() != 0) begin
        $display("group %0d never received %0d expected parts", g, expected_q[g].size());
        errors++;
      end
    end
    report_test("drain and backend idle");

    $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog scaled by the number of requests
  initial begin
    wait (patterns_loaded);
    repeat (num_patterns * CyclesPerPattern) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d requests completed",
             num_patterns * CyclesPerPattern, completions, num_patterns);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/dma_patterns.txt
// Columns: src dst num_bytes, all hex, one request per line
// TCDM spans 00010000 to 00010fff, rows of 64 bytes, stripes of 16
80000000 00010010 0008 // inside one stripe of group 1
00010104 90000000 0030 // source side in the TCDM, four stripes
80000000 00010038 0050 // crosses stripes and a row
80001000 90002000 0100 // neither address in the TCDM
80000000 00010020 0000 // zero bytes
00010ff0 a0000000 0020 // runs past the end of the TCDM
00010210 00010300 0044 // both in the TCDM, destination decides
8000002c 0001007a 0040 // unaligned across a row
00010000 90000000 0040 // one full aligned row
80000100 00010404 0004 // single bank
00010a3c 90000040 0070 // source side across two rows

// File: project.f
design/dma_pkg.sv
design/dma_spill_register.sv
design/dma_row_splitter.sv
design/dma_group_distributor.sv
design/dma_completion_tracker.sv
design/dma_cluster_frontend.sv
tb/tb_clock_gen.sv
tb/dma_cluster_assert.sv
tb/tb_dma_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_dma_cluster -o sim_dma_cluster

status=0
./obj_dir/sim_dma_cluster > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed"
  exit 1
fi
echo "run passed"
